//--- hdl/lsuOutPkg.sv
// Load/store coalescing package with segment geometry, lane address view and line types
package lsuOutPkg;

	//////////////////////////////////////////////////
	// Segment geometry
	//////////////////////////////////////////////////
	localparam int ADDR_WIDTH = 32;
	localparam int WORD_BYTES = 4;
	localparam int SEGMENT_BYTES = 64;
	localparam int SEGMENT_WORDS = SEGMENT_BYTES / WORD_BYTES;
	localparam int WORD_INDEX_WIDTH = $clog2(SEGMENT_WORDS);
	localparam int BYTE_OFFSET_WIDTH = $clog2(WORD_BYTES);
	localparam int SEGMENT_WIDTH = ADDR_WIDTH - WORD_INDEX_WIDTH - BYTE_OFFSET_WIDTH;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////
	typedef logic [SEGMENT_WIDTH-1:0] segmentAddr_t;
	typedef logic [WORD_BYTES*8-1:0] word_t;
	typedef logic [SEGMENT_BYTES-1:0] byteMask_t;
	typedef logic [SEGMENT_BYTES*8-1:0] line_t;
	typedef logic [4:0] warpId_t;
	typedef logic [4:0] regId_t;

	// One lane address, seen as a plain word or split into line, word and byte
	typedef union packed {
		logic [ADDR_WIDTH-1:0] raw;
		struct packed {
			segmentAddr_t segment;
			logic [WORD_INDEX_WIDTH-1:0] wordIndex;
			// Byte offset is ignored, lanes move whole words
			logic [BYTE_OFFSET_WIDTH-1:0] byteOffset;
		} field;
	} laneAddr_u;

endpackage

//--- hdl/laneWriteIf.sv
// Lane merge channel from the lane selector into the segment line buffer
interface laneWriteIf;
	import lsuOutPkg::*;

	logic write;
	logic [WORD_INDEX_WIDTH-1:0] wordIndex;
	word_t data;
	logic first;
	logic last;
	// Line tags, valid with first
	segmentAddr_t segment;
	warpId_t warp;
	regId_t regId;
	logic isWrite;
	// High while a finished line still waits for the issuer
	logic lineHeld;

	modport producer (output write, wordIndex, data, first, last, segment, warp, regId,
		isWrite, input lineHeld);
	modport buffer (input write, wordIndex, data, first, last, segment, warp, regId,
		isWrite, output lineHeld);
endinterface

//--- hdl/segmentLineIf.sv
// Finished segment line channel from the line buffer to the memory request issuer
interface segmentLineIf;
	import lsuOutPkg::*;

	logic lineValid;
	segmentAddr_t segment;
	byteMask_t byteMask;
	line_t data;
	warpId_t warp;
	regId_t regId;
	logic isWrite;
	// One cycle pulse, the line was copied into the memory request
	logic lineTaken;

	modport buffer (
		output lineValid, segment, byteMask, data, warp, regId, isWrite,
		input lineTaken
	);
	modport issuer (
		input lineValid, segment, byteMask, data, warp, regId, isWrite,
		output lineTaken
	);
endinterface

//--- hdl/laneSelector.sv
// Lane selector, captures a warp request and emits its active lanes lowest first
module laneSelector #(
	parameter int NUM_LANES = 8
) (
	input logic clk,
	input logic reset,
	input logic reqValid_i,
	input logic [NUM_LANES-1:0] reqLaneMask_i,
	input lsuOutPkg::laneAddr_u reqAddr_i [NUM_LANES],
	input lsuOutPkg::word_t reqData_i [NUM_LANES],
	input lsuOutPkg::warpId_t reqWarp_i,
	input lsuOutPkg::regId_t reqReg_i,
	input logic reqWrite_i,
	output logic lsuBusy_o,
	laneWriteIf.producer laneOut
);
	import lsuOutPkg::*;

	localparam int LANE_IDX_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [NUM_LANES-1:0] pendMask;
	logic [NUM_LANES-1:0] remainMask;
	logic [LANE_IDX_WIDTH-1:0] laneIdx;
	logic firstQ;
	logic advance;
	logic accept;

	laneAddr_u addrQ [NUM_LANES];
	word_t dataQ [NUM_LANES];
	warpId_t warpQ;
	regId_t regQ;
	logic writeQ;

	//////////////////////////////////////////////////
	// Lane walk
	//////////////////////////////////////////////////

	// Priority encoder, lowest pending lane wins
	always_comb begin
		laneIdx = '0;
		for (int i = NUM_LANES - 1; i >= 0; i--) begin
			if (pendMask[i]) begin
				laneIdx = LANE_IDX_WIDTH'(i);
			end
		end
	end

	// Same lane as the encoder, cleared by the lowest set bit trick
	assign remainMask = pendMask & (pendMask - 1'b1);

	assign lsuBusy_o = |pendMask;
	assign accept = reqValid_i && !lsuBusy_o;
	// A held line blocks the first write of the next one
	assign advance = lsuBusy_o && !laneOut.lineHeld;

	always_ff @(posedge clk) begin
		if (reset) begin
			pendMask <= '0;
			firstQ <= 1'b0;
		end else if (accept) begin
			pendMask <= reqLaneMask_i;
			firstQ <= 1'b1;
		end else if (advance) begin
			pendMask <= remainMask;
			firstQ <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addrQ <= reqAddr_i;
			dataQ <= reqData_i;
			warpQ <= reqWarp_i;
			regQ <= reqReg_i;
			writeQ <= reqWrite_i;
		end
	end

	//////////////////////////////////////////////////
	// Merge write
	//////////////////////////////////////////////////
	assign laneOut.write = advance;
	assign laneOut.wordIndex = addrQ[laneIdx].field.wordIndex;
	assign laneOut.data = dataQ[laneIdx];
	assign laneOut.first = firstQ;
	assign laneOut.last = (remainMask == '0);
	// On the first write this is the lowest active lane
	assign laneOut.segment = addrQ[laneIdx].field.segment;
	assign laneOut.warp = warpQ;
	assign laneOut.regId = regQ;
	assign laneOut.isWrite = writeQ;

endmodule

//--- hdl/segmentLineBuffer.sv
// Segment line buffer, merges lane words into a 64 byte line and byte mask
module segmentLineBuffer (
	input logic clk,
	input logic reset,
	laneWriteIf.buffer laneIn,
	segmentLineIf.buffer lineOut
);
	import lsuOutPkg::*;

	logic lineValidQ;
	logic storeNow;
	byteMask_t maskQ;
	byteMask_t maskNext;
	line_t dataQ;
	line_t dataNext;
	segmentAddr_t segmentQ;
	warpId_t warpQ;
	regId_t regQ;
	logic isWriteQ;

	// A first write starts from an empty line
	always_comb begin
		maskNext = laneIn.first ? '0 : maskQ;
		dataNext = laneIn.first ? '0 : dataQ;
		storeNow = laneIn.first ? laneIn.isWrite : isWriteQ;
		maskNext[laneIn.wordIndex * WORD_BYTES +: WORD_BYTES] = '1;
		// Loads only mark bytes, later lanes overwrite earlier ones
		if (storeNow) begin
			dataNext[laneIn.wordIndex * WORD_BYTES * 8 +: WORD_BYTES * 8] = laneIn.data;
		end
	end

	always_ff @(posedge clk) begin
		if (laneIn.write) begin
			maskQ <= maskNext;
			dataQ <= dataNext;
			if (laneIn.first) begin
				segmentQ <= laneIn.segment;
				warpQ <= laneIn.warp;
				regQ <= laneIn.regId;
				isWriteQ <= laneIn.isWrite;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lineValidQ <= 1'b0;
		end else if (laneIn.write && laneIn.last) begin
			lineValidQ <= 1'b1;
		end else if (lineOut.lineTaken) begin
			lineValidQ <= 1'b0;
		end
	end

	assign laneIn.lineHeld = lineValidQ;

	assign lineOut.lineValid = lineValidQ;
	assign lineOut.segment = segmentQ;
	assign lineOut.byteMask = maskQ;
	assign lineOut.data = dataQ;
	assign lineOut.warp = warpQ;
	assign lineOut.regId = regQ;
	assign lineOut.isWrite = isWriteQ;

endmodule

//--- hdl/memRequestIssuer.sv
// Memory request issuer, sends a held segment line once memory shows ready
module memRequestIssuer (
	input logic clk,
	input logic reset,
	segmentLineIf.issuer lineIn,
	input logic memReady_i,
	output logic memReq_o,
	output lsuOutPkg::segmentAddr_t memAddr_o,
	output lsuOutPkg::byteMask_t memByteMask_o,
	output lsuOutPkg::line_t memData_o,
	output lsuOutPkg::warpId_t memWarp_o,
	output lsuOutPkg::regId_t memReg_o,
	output logic memWrite_o
);
	logic issue;

	// The line stays valid during the take cycle, so skip it then
	assign issue = lineIn.lineValid && !memReq_o && memReady_i;

	always_ff @(posedge clk) begin
		if (reset) begin
			memReq_o <= 1'b0;
		end else begin
			memReq_o <= issue;
		end
	end

	// Outputs hold until the next issue
	always_ff @(posedge clk) begin
		if (issue) begin
			memAddr_o <= lineIn.segment;
			memByteMask_o <= lineIn.byteMask;
			memData_o <= lineIn.data;
			memWarp_o <= lineIn.warp;
			memReg_o <= lineIn.regId;
			memWrite_o <= lineIn.isWrite;
		end
	end

	assign lineIn.lineTaken = memReq_o;

endmodule

//--- hdl/lsuOutUnit.sv
// Warp load/store coalescing unit, lane selector to line buffer to memory issuer
module lsuOutUnit #(
	parameter int NUM_LANES = 8
) (
	input logic clk,
	input logic reset,
	// Warp request
	input logic reqValid_i,
	input logic [NUM_LANES-1:0] reqLaneMask_i,
	input lsuOutPkg::laneAddr_u reqAddr_i [NUM_LANES],
	input lsuOutPkg::word_t reqData_i [NUM_LANES],
	input lsuOutPkg::warpId_t reqWarp_i,
	input lsuOutPkg::regId_t reqReg_i,
	input logic reqWrite_i,
	output logic lsuBusy_o,
	// Memory side
	input logic memReady_i,
	output logic memReq_o,
	output lsuOutPkg::segmentAddr_t memAddr_o,
	output lsuOutPkg::byteMask_t memByteMask_o,
	output lsuOutPkg::line_t memData_o,
	output lsuOutPkg::warpId_t memWarp_o,
	output lsuOutPkg::regId_t memReg_o,
	output logic memWrite_o
);

	laneWriteIf laneWrite ();
	segmentLineIf segmentLine ();

	laneSelector #(
		.NUM_LANES(NUM_LANES)
	) i_laneSelector (
		.clk(clk),
		.reset(reset),
		.reqValid_i(reqValid_i),
		.reqLaneMask_i(reqLaneMask_i),
		.reqAddr_i(reqAddr_i),
		.reqData_i(reqData_i),
		.reqWarp_i(reqWarp_i),
		.reqReg_i(reqReg_i),
		.reqWrite_i(reqWrite_i),
		.lsuBusy_o(lsuBusy_o),
		.laneOut(laneWrite.producer)
	);

	segmentLineBuffer i_segmentLineBuffer (
		.clk(clk),
		.reset(reset),
		.laneIn(laneWrite.buffer),
		.lineOut(segmentLine.buffer)
	);

	memRequestIssuer i_memRequestIssuer (
		.clk(clk),
		.reset(reset),
		.lineIn(segmentLine.issuer),
		.memReady_i(memReady_i),
		.memReq_o(memReq_o),
		.memAddr_o(memAddr_o),
		.memByteMask_o(memByteMask_o),
		.memData_o(memData_o),
		.memWarp_o(memWarp_o),
		.memReg_o(memReg_o),
		.memWrite_o(memWrite_o)
	);

endmodule

//--- verification/lsuOutUnit_checker.sv
// Memory side assertions for the warp load/store coalescing unit
module lsuOutUnit_checker (
	input logic clk,
	input logic reset,
	input logic memReady_i,
	input logic memReq_i,
	input lsuOutPkg::byteMask_t memByteMask_i
);

	// Request output is cleared by reset
	resetClearsReq: assert property (@(posedge clk) reset |=> !memReq_i)
		else $error("memory request high after a reset cycle");

	// An issue needs memory ready on the edge before
	reqNeedsReady: assert property (@(posedge clk) disable iff (reset)
		memReq_i |-> $past(memReady_i))
		else $error("memory request without ready in the previous cycle");

	// Every issued line covers at least one word
	reqHasBytes: assert property (@(posedge clk) disable iff (reset)
		memReq_i |-> (memByteMask_i != '0))
		else $error("memory request with an empty byte mask");

endmodule

bind lsuOutUnit lsuOutUnit_checker i_lsuOutUnitChecker (
	.clk(clk),
	.reset(reset),
	.memReady_i(memReady_i),
	.memReq_i(memReq_o),
	.memByteMask_i(memByteMask_o)
);

//--- verification/lsuOutUnitTb.sv
// Directed testbench for the warp load/store coalescing unit
module lsuOutUnitTb;
	import lsuOutPkg::*;

	localparam int NUM_LANES = 8;
	localparam int TIMEOUT = 100;

	logic clk;
	logic reset;
	logic reqValid;
	logic [NUM_LANES-1:0] reqLaneMask;
	laneAddr_u reqAddr [NUM_LANES];
	word_t reqData [NUM_LANES];
	warpId_t reqWarp;
	regId_t reqReg;
	logic reqWrite;
	logic lsuBusy;
	logic memReady;
	logic memReq;
	segmentAddr_t memAddr;
	byteMask_t memByteMask;
	line_t memData;
	warpId_t memWarp;
	regId_t memReg;
	logic memWrite;

	integer seed = 35822;
	int errors = 0;

	// Expected memory requests, one slot per request in flight
	segmentAddr_t expAddr [2];
	byteMask_t expMask [2];
	line_t expLine [2];
	warpId_t expWarp [2];
	regId_t expReg [2];
	logic expWrite [2];

	lsuOutUnit #(
		.NUM_LANES(NUM_LANES)
	) i_lsuOutUnit (
		.clk(clk),
		.reset(reset),
		.reqValid_i(reqValid),
		.reqLaneMask_i(reqLaneMask),
		.reqAddr_i(reqAddr),
		.reqData_i(reqData),
		.reqWarp_i(reqWarp),
		.reqReg_i(reqReg),
		.reqWrite_i(reqWrite),
		.lsuBusy_o(lsuBusy),
		.memReady_i(memReady),
		.memReq_o(memReq),
		.memAddr_o(memAddr),
		.memByteMask_o(memByteMask),
		.memData_o(memData),
		.memWarp_o(memWarp),
		.memReg_o(memReg),
		.memWrite_o(memWrite)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic checkSegment(input string name, input segmentAddr_t got, input segmentAddr_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkMask(input string name, input byteMask_t got, input byteMask_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkLine(input string name, input line_t got, input line_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkTag(input string name, input warpId_t got, input warpId_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus and reference model
	//////////////////////////////////////////////////

	// Lowest active lane gives the segment, higher lanes win a shared word
	task automatic buildExpected(input int slot);
		logic found;
		int base;
		found = 1'b0;
		expMask[slot] = '0;
		expLine[slot] = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			if (reqLaneMask[i]) begin
				if (!found) begin
					expAddr[slot] = reqAddr[i].field.segment;
					found = 1'b1;
				end
				base = int'(reqAddr[i].field.wordIndex) * WORD_BYTES;
				expMask[slot][base +: WORD_BYTES] = '1;
				if (reqWrite) begin
					expLine[slot][base * 8 +: WORD_BYTES * 8] = reqData[i];
				end
			end
		end
		expWarp[slot] = reqWarp;
		expReg[slot] = reqReg;
		expWrite[slot] = reqWrite;
	endtask

	// Random upper bits on every lane, word index from a stride
	task automatic setLanes(input int stride, input int offset);
		for (int i = 0; i < NUM_LANES; i++) begin
			reqAddr[i].raw = $random(seed);
			reqAddr[i].field.wordIndex = WORD_INDEX_WIDTH'((i * stride + offset) % SEGMENT_WORDS);
			reqData[i] = $random(seed);
		end
	endtask

	task automatic sendRequest(input logic [NUM_LANES-1:0] mask, input logic isWrite, input int slot);
		int cycles;
		cycles = 0;
		while (lsuBusy && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (lsuBusy) begin
			$display("error at %0t: unit stayed busy, request could not be sent", $time);
			errors++;
		end
		reqLaneMask = mask;
		reqWarp = warpId_t'($random(seed));
		reqReg = regId_t'($random(seed));
		reqWrite = isWrite;
		reqValid = 1'b1;
		buildExpected(slot);
		@(negedge clk);
		reqValid = 1'b0;
	endtask

	task automatic checkIssue(input int slot);
		int cycles;
		cycles = 0;
		while (!memReq && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (!memReq) begin
			$display("error at %0t: no memory request arrived within the timeout", $time);
			errors++;
		end else begin
			checkSegment("memAddr_o", memAddr, expAddr[slot]);
			checkMask("memByteMask_o", memByteMask, expMask[slot]);
			checkLine("memData_o", memData, expLine[slot]);
			checkTag("memWarp_o", memWarp, expWarp[slot]);
			checkTag("memReg_o", memReg, expReg[slot]);
			checkBit("memWrite_o", memWrite, expWrite[slot]);
			@(negedge clk);
			// Request is a single cycle pulse
			checkBit("memReq_o", memReq, 1'b0);
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////
	task automatic singleStoreTest();
		setLanes(1, 5);
		sendRequest(8'b0000_0100, 1'b1, 0);
		checkIssue(0);
	endtask

	task automatic fullStoreTest();
		setLanes(3, 1);
		sendRequest('1, 1'b1, 0);
		checkIssue(0);
	endtask

	task automatic collisionTest();
		setLanes(1, 0);
		reqAddr[6].field.wordIndex = reqAddr[2].field.wordIndex;
		sendRequest(8'b0100_0110, 1'b1, 0);
		checkIssue(0);
	endtask

	task automatic loadTest();
		setLanes(2, 0);
		sendRequest(8'hF0, 1'b0, 0);
		checkIssue(0);
	endtask

	task automatic backPressureTest();
		memReady = 1'b0;
		setLanes(3, 2);
		sendRequest(8'b1010_1011, 1'b1, 0);
		setLanes(5, 7);
		sendRequest(8'b0111_0000, 1'b0, 1);
		// Second request waits behind the parked first line
		for (int i = 0; i < 20; i++) begin
			checkBit("memReq_o", memReq, 1'b0);
			checkBit("lsuBusy_o", lsuBusy, 1'b1);
			@(negedge clk);
		end
		memReady = 1'b1;
		checkIssue(0);
		checkIssue(1);
	endtask

	task automatic emptyMaskTest();
		setLanes(1, 0);
		sendRequest('0, 1'b1, 0);
		for (int i = 0; i < TIMEOUT; i++) begin
			checkBit("memReq_o", memReq, 1'b0);
			checkBit("lsuBusy_o", lsuBusy, 1'b0);
			@(negedge clk);
		end
	endtask

	initial begin
		reset = 1'b1;
		reqValid = 1'b0;
		reqLaneMask = '0;
		reqWarp = '0;
		reqReg = '0;
		reqWrite = 1'b0;
		memReady = 1'b1;
		for (int i = 0; i < NUM_LANES; i++) begin
			reqAddr[i] = '0;
			reqData[i] = '0;
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		singleStoreTest();
		fullStoreTest();
		collisionTest();
		loadTest();
		backPressureTest();
		emptyMaskTest();
		$display("Tests finished, error count %0d", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- flist.f
hdl/lsuOutPkg.sv
hdl/laneWriteIf.sv
hdl/segmentLineIf.sv
hdl/laneSelector.sv
hdl/segmentLineBuffer.sv
hdl/memRequestIssuer.sv
hdl/lsuOutUnit.sv
verification/lsuOutUnit_checker.sv
verification/lsuOutUnitTb.sv

//--- Makefile
TOOL       = verilator
LINT_FLAGS = --lint-only -Wall -Wno-fatal --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = lsuOutUnitTb
RTL_TOP    = lsuOutUnit
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
